//--- flist.f
logic/axi_adapter_pkg.sv
logic/axi_write_engine.sv
logic/axi_read_engine.sv
logic/axi_adapter.sv
verification/axi_mem_slave.sv
verification/tb_axi_adapter.sv

//--- logic/axi_adapter.sv
`default_nettype none

module axi_adapter (
  input  logic                                                     clk_i,
  input  logic                                                     rst_ni,
  // requester
  input  logic                                                     req_i,
  input  logic                                                     line_i,
  input  logic                                                     we_i,
  input  logic [axi_adapter_pkg::ADDR_W-1:0]                       addr_i,
  input  logic [1:0]                                               size_i,
  input  logic [axi_adapter_pkg::ID_W-1:0]                         id_i,
  input  logic [axi_adapter_pkg::LINE_W-1:0]                       wdata_i,
  input  logic [axi_adapter_pkg::BEATS*axi_adapter_pkg::STRB_W-1:0] be_i,
  output logic                                                     gnt_o,
  output logic                                                     valid_o,
  output logic [axi_adapter_pkg::LINE_W-1:0]                       rdata_o,
  output logic [axi_adapter_pkg::ID_W-1:0]                         id_o,
  output logic [axi_adapter_pkg::DATA_W-1:0]                       critical_word_o,
  output logic                                                     critical_word_valid_o,
  // AXI write side
  output logic                                                     aw_valid_o,
  input  logic                                                     aw_ready_i,
  output logic [axi_adapter_pkg::ADDR_W-1:0]                       aw_addr_o,
  output logic [axi_adapter_pkg::LEN_W-1:0]                        aw_len_o,
  output logic [axi_adapter_pkg::SIZE_W-1:0]                       aw_size_o,
  output logic [axi_adapter_pkg::ID_W-1:0]                         aw_id_o,
  output logic                                                     w_valid_o,
  input  logic                                                     w_ready_i,
  output logic [axi_adapter_pkg::DATA_W-1:0]                       w_data_o,
  output logic [axi_adapter_pkg::STRB_W-1:0]                       w_strb_o,
  output logic                                                     w_last_o,
  input  logic                                                     b_valid_i,
  output logic                                                     b_ready_o,
  input  logic [axi_adapter_pkg::ID_W-1:0]                         b_id_i,
  // AXI read side
  output logic                                                     ar_valid_o,
  input  logic                                                     ar_ready_i,
  output logic [axi_adapter_pkg::ADDR_W-1:0]                       ar_addr_o,
  output logic [axi_adapter_pkg::LEN_W-1:0]                        ar_len_o,
  output logic [axi_adapter_pkg::SIZE_W-1:0]                       ar_size_o,
  output logic [axi_adapter_pkg::ID_W-1:0]                         ar_id_o,
  input  logic                                                     r_valid_i,
  output logic                                                     r_ready_o,
  input  logic [axi_adapter_pkg::DATA_W-1:0]                       r_data_i,
  input  logic [axi_adapter_pkg::ID_W-1:0]                         r_id_i,
  input  logic                                                     r_last_i
);

  import axi_adapter_pkg::*;

  logic            wr_gnt;
  logic            rd_gnt;
  logic            wr_busy;
  logic            rd_busy;
  logic            wr_done;
  logic [ID_W-1:0] wr_id;

  // only one engine serves the held request
  assign gnt_o = wr_gnt | rd_gnt;

  axi_write_engine u_write_engine (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .req_i      (req_i),
    .we_i       (we_i),
    .line_i     (line_i),
    .addr_i     (addr_i),
    .size_i     (size_i),
    .id_i       (id_i),
    .wdata_i    (wdata_i),
    .be_i       (be_i),
    .rd_busy_i  (rd_busy),
    .wr_gnt_o   (wr_gnt),
    .aw_valid_o (aw_valid_o),
    .aw_ready_i (aw_ready_i),
    .aw_addr_o  (aw_addr_o),
    .aw_len_o   (aw_len_o),
    .aw_size_o  (aw_size_o),
    .aw_id_o    (aw_id_o),
    .w_valid_o  (w_valid_o),
    .w_ready_i  (w_ready_i),
    .w_data_o   (w_data_o),
    .w_strb_o   (w_strb_o),
    .w_last_o   (w_last_o),
    .b_valid_i  (b_valid_i),
    .b_ready_o  (b_ready_o),
    .b_id_i     (b_id_i),
    .wr_busy_o  (wr_busy),
    .wr_done_o  (wr_done),
    .wr_id_o    (wr_id)
  );

  axi_read_engine u_read_engine (
    .clk_i                 (clk_i),
    .rst_ni                (rst_ni),
    .req_i                 (req_i),
    .we_i                  (we_i),
    .line_i                (line_i),
    .addr_i                (addr_i),
    .size_i                (size_i),
    .id_i                  (id_i),
    .rd_gnt_o              (rd_gnt),
    .wr_busy_i             (wr_busy),
    .wr_done_i             (wr_done),
    .wr_id_i               (wr_id),
    .ar_valid_o            (ar_valid_o),
    .ar_ready_i            (ar_ready_i),
    .ar_addr_o             (ar_addr_o),
    .ar_len_o              (ar_len_o),
    .ar_size_o             (ar_size_o),
    .ar_id_o               (ar_id_o),
    .r_valid_i             (r_valid_i),
    .r_ready_o             (r_ready_o),
    .r_data_i              (r_data_i),
    .r_id_i                (r_id_i),
    .r_last_i              (r_last_i),
    .rd_busy_o             (rd_busy),
    .valid_o               (valid_o),
    .rdata_o               (rdata_o),
    .id_o                  (id_o),
    .critical_word_o       (critical_word_o),
    .critical_word_valid_o (critical_word_valid_o)
  );

endmodule

`default_nettype wire

//--- logic/axi_adapter_pkg.sv
`default_nettype none

package axi_adapter_pkg;

  // --------------------
  // word geometry
  // --------------------

  // request and AXI address width
  localparam int ADDR_W = 32;
  // one word is one AXI data beat
  localparam int DATA_W = 64;
  localparam int STRB_W = DATA_W / 8;

  // --------------------
  // line geometry
  // --------------------

  localparam int LINE_W = 256;
  localparam int BEATS = LINE_W / DATA_W;
  // word index inside a line
  localparam int BEAT_IDX_W = 2;
  // byte offset of a line, cleared in line addresses
  localparam int LINE_OFF_W = 5;
  // byte offset of a word, word index sits just above
  localparam int WORD_OFF_W = 3;

  // --------------------
  // AXI fields
  // --------------------

  localparam int ID_W = 4;
  localparam int LEN_W = 8;
  localparam int SIZE_W = 3;
  // burst length field of a full line
  localparam int LINE_LEN = BEATS - 1;

endpackage

`default_nettype wire

//--- logic/axi_read_engine.sv
`default_nettype none

module axi_read_engine (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  // requester
  input  logic                                req_i,
  input  logic                                we_i,
  input  logic                                line_i,
  input  logic [axi_adapter_pkg::ADDR_W-1:0]  addr_i,
  input  logic [1:0]                          size_i,
  input  logic [axi_adapter_pkg::ID_W-1:0]    id_i,
  output logic                                rd_gnt_o,
  // from the write engine
  input  logic                                wr_busy_i,
  input  logic                                wr_done_i,
  input  logic [axi_adapter_pkg::ID_W-1:0]    wr_id_i,
  // AR channel
  output logic                                ar_valid_o,
  input  logic                                ar_ready_i,
  output logic [axi_adapter_pkg::ADDR_W-1:0]  ar_addr_o,
  output logic [axi_adapter_pkg::LEN_W-1:0]   ar_len_o,
  output logic [axi_adapter_pkg::SIZE_W-1:0]  ar_size_o,
  output logic [axi_adapter_pkg::ID_W-1:0]    ar_id_o,
  // R channel
  input  logic                                r_valid_i,
  output logic                                r_ready_o,
  input  logic [axi_adapter_pkg::DATA_W-1:0]  r_data_i,
  input  logic [axi_adapter_pkg::ID_W-1:0]    r_id_i,
  input  logic                                r_last_i,
  output logic                                rd_busy_o,
  // response port
  output logic                                valid_o,
  output logic [axi_adapter_pkg::LINE_W-1:0]  rdata_o,
  output logic [axi_adapter_pkg::ID_W-1:0]    id_o,
  output logic [axi_adapter_pkg::DATA_W-1:0]  critical_word_o,
  output logic                                critical_word_valid_o
);

  import axi_adapter_pkg::*;

  enum logic [1:0] {
    IDLE,
    WAIT_R,
    COMPLETE
  } state_q, state_d;

  logic [BEAT_IDX_W-1:0] cnt_q, cnt_d;
  // word index of the requested address
  logic [BEAT_IDX_W-1:0] offset_q, offset_d;
  logic [ID_W-1:0]       id_q, id_d;
  logic                  is_line_q, is_line_d;
  logic [LINE_W-1:0]     line_q;
  logic [BEAT_IDX_W-1:0] beat_idx;
  logic                  rd_req;
  logic                  r_beat;

  assign rd_req   = req_i & ~we_i & ~wr_busy_i;
  assign r_beat   = (state_q == WAIT_R) & r_valid_i;
  // single reads always land in word 0
  assign beat_idx = is_line_q ? cnt_q : '0;

  // --------------------
  // address phase
  // --------------------

  always_comb begin
    ar_addr_o = addr_i;
    if (line_i) begin
      ar_addr_o[LINE_OFF_W-1:0] = '0;
    end
    ar_len_o  = line_i ? LEN_W'(LINE_LEN) : '0;
    ar_size_o = line_i ? SIZE_W'(WORD_OFF_W) : {1'b0, size_i};
  end

  assign ar_id_o = id_i;

  // --------------------
  // FSM
  // --------------------

  always_comb begin
    state_d    = state_q;
    cnt_d      = cnt_q;
    offset_d   = offset_q;
    id_d       = id_q;
    is_line_d  = is_line_q;
    ar_valid_o = 1'b0;
    rd_gnt_o   = 1'b0;
    r_ready_o  = 1'b0;

    unique case (state_q)
      IDLE: begin
        if (rd_req) begin
          ar_valid_o = 1'b1;
          rd_gnt_o   = ar_ready_i;
          if (ar_ready_i) begin
            state_d   = WAIT_R;
            cnt_d     = '0;
            offset_d  = addr_i[WORD_OFF_W +: BEAT_IDX_W];
            is_line_d = line_i;
          end
        end
      end

      WAIT_R: begin
        r_ready_o = 1'b1;
        if (r_valid_i) begin
          cnt_d = cnt_q + 1'b1;
          if (r_last_i) begin
            id_d    = r_id_i;
            state_d = COMPLETE;
          end
        end
      end

      // line buffer is complete, hand it out
      COMPLETE: state_d = IDLE;

      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q   <= IDLE;
      cnt_q     <= '0;
      offset_q  <= '0;
      id_q      <= '0;
      is_line_q <= 1'b0;
    end else begin
      state_q   <= state_d;
      cnt_q     <= cnt_d;
      offset_q  <= offset_d;
      id_q      <= id_d;
      is_line_q <= is_line_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (r_beat) begin
      line_q[beat_idx*DATA_W +: DATA_W] <= r_data_i;
    end
  end

  // --------------------
  // response port
  // --------------------

  // write completions share valid_o and id_o, never in the same cycle as a read
  always_comb begin
    valid_o = 1'b0;
    id_o    = id_q;
    if (state_q == COMPLETE) begin
      valid_o = 1'b1;
    end else if (wr_done_i) begin
      valid_o = 1'b1;
      id_o    = wr_id_i;
    end
  end

  assign rdata_o               = line_q;
  assign rd_busy_o             = (state_q != IDLE);
  assign critical_word_o       = r_data_i;
  assign critical_word_valid_o = r_beat & is_line_q & (cnt_q == offset_q);

  // slave ends a line burst on its fourth beat and not before
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    r_beat && is_line_q |-> (r_last_i == (cnt_q == BEAT_IDX_W'(LINE_LEN))));

endmodule

`default_nettype wire

//--- logic/axi_write_engine.sv
`default_nettype none

module axi_write_engine (
  input  logic                                                     clk_i,
  input  logic                                                     rst_ni,
  // requester
  input  logic                                                     req_i,
  input  logic                                                     we_i,
  input  logic                                                     line_i,
  input  logic [axi_adapter_pkg::ADDR_W-1:0]                       addr_i,
  input  logic [1:0]                                               size_i,
  input  logic [axi_adapter_pkg::ID_W-1:0]                         id_i,
  input  logic [axi_adapter_pkg::LINE_W-1:0]                       wdata_i,
  input  logic [axi_adapter_pkg::BEATS*axi_adapter_pkg::STRB_W-1:0] be_i,
  input  logic                                                     rd_busy_i,
  output logic                                                     wr_gnt_o,
  // AW channel
  output logic                                                     aw_valid_o,
  input  logic                                                     aw_ready_i,
  output logic [axi_adapter_pkg::ADDR_W-1:0]                       aw_addr_o,
  output logic [axi_adapter_pkg::LEN_W-1:0]                        aw_len_o,
  output logic [axi_adapter_pkg::SIZE_W-1:0]                       aw_size_o,
  output logic [axi_adapter_pkg::ID_W-1:0]                         aw_id_o,
  // W channel
  output logic                                                     w_valid_o,
  input  logic                                                     w_ready_i,
  output logic [axi_adapter_pkg::DATA_W-1:0]                       w_data_o,
  output logic [axi_adapter_pkg::STRB_W-1:0]                       w_strb_o,
  output logic                                                     w_last_o,
  // B channel
  input  logic                                                     b_valid_i,
  output logic                                                     b_ready_o,
  input  logic [axi_adapter_pkg::ID_W-1:0]                         b_id_i,
  // to the read engine
  output logic                                                     wr_busy_o,
  output logic                                                     wr_done_o,
  output logic [axi_adapter_pkg::ID_W-1:0]                         wr_id_o
);

  import axi_adapter_pkg::*;

  enum logic [2:0] {
    IDLE,
    WAIT_AW,
    WAIT_W,
    WAIT_W_AW,
    WAIT_AW_BURST,
    WAIT_B
  } state_q, state_d;

  // word currently offered on W
  logic [BEAT_IDX_W-1:0] cnt_q, cnt_d;
  logic                  wr_req;
  logic                  last_beat;

  assign wr_req    = req_i & we_i & ~rd_busy_i;
  assign last_beat = ~line_i | (cnt_q == BEAT_IDX_W'(LINE_LEN));

  // --------------------
  // address and data
  // --------------------

  // line bursts start at the line base with full-word beats
  always_comb begin
    aw_addr_o = addr_i;
    if (line_i) begin
      aw_addr_o[LINE_OFF_W-1:0] = '0;
    end
    aw_len_o  = line_i ? LEN_W'(LINE_LEN) : '0;
    aw_size_o = line_i ? SIZE_W'(WORD_OFF_W) : {1'b0, size_i};
  end

  assign aw_id_o  = id_i;
  assign w_data_o = wdata_i[cnt_q*DATA_W +: DATA_W];
  assign w_strb_o = be_i[cnt_q*STRB_W +: STRB_W];
  assign w_last_o = w_valid_o & last_beat;

  assign wr_busy_o = (state_q != IDLE);
  assign wr_id_o   = b_id_i;

  // --------------------
  // FSM
  // --------------------

  always_comb begin
    state_d    = state_q;
    cnt_d      = cnt_q;
    aw_valid_o = 1'b0;
    w_valid_o  = 1'b0;
    b_ready_o  = 1'b0;
    wr_gnt_o   = 1'b0;
    wr_done_o  = 1'b0;

    unique case (state_q)
      IDLE: begin
        if (wr_req) begin
          aw_valid_o = 1'b1;
          w_valid_o  = 1'b1;
          if (!line_i) begin
            wr_gnt_o = aw_ready_i & w_ready_i;
            unique case ({aw_ready_i, w_ready_i})
              2'b11:   state_d = WAIT_B;
              2'b10:   state_d = WAIT_W;
              2'b01:   state_d = WAIT_AW;
              default: state_d = IDLE;
            endcase
          end else begin
            if (w_ready_i) begin
              cnt_d = cnt_q + 1'b1;
            end
            if (aw_ready_i) begin
              state_d = WAIT_W;
            end else if (w_ready_i) begin
              state_d = WAIT_W_AW;
            end
          end
        end
      end

      // only the address is left
      WAIT_AW, WAIT_AW_BURST: begin
        aw_valid_o = 1'b1;
        if (aw_ready_i) begin
          wr_gnt_o = 1'b1;
          state_d  = WAIT_B;
        end
      end

      // address taken, data beats remain
      WAIT_W: begin
        w_valid_o = 1'b1;
        if (w_ready_i) begin
          if (last_beat) begin
            wr_gnt_o = 1'b1;
            state_d  = WAIT_B;
          end else begin
            cnt_d = cnt_q + 1'b1;
          end
        end
      end

      WAIT_W_AW: begin
        aw_valid_o = 1'b1;
        w_valid_o  = 1'b1;
        if (w_ready_i && last_beat) begin
          if (aw_ready_i) begin
            wr_gnt_o = 1'b1;
            state_d  = WAIT_B;
          end else begin
            state_d = WAIT_AW_BURST;
          end
        end else begin
          if (w_ready_i) begin
            cnt_d = cnt_q + 1'b1;
          end
          if (aw_ready_i) begin
            state_d = WAIT_W;
          end
        end
      end

      WAIT_B: begin
        b_ready_o = 1'b1;
        cnt_d     = '0;
        if (b_valid_i) begin
          wr_done_o = 1'b1;
          state_d   = IDLE;
        end
      end

      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      cnt_q   <= cnt_d;
    end
  end

  // --------------------
  // protocol checks
  // --------------------

  // valid holds with its payload until the slave takes it
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    aw_valid_o && !aw_ready_i |=> aw_valid_o && $stable(aw_addr_o));
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    w_valid_o && !w_ready_i |=> w_valid_o && $stable(w_data_o));

  // nothing follows the accepted last beat
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    w_last_o && w_ready_i |=> !w_valid_o);

endmodule

`default_nettype wire

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the AXI adapter testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --timing --assert --top-module tb_axi_adapter -f flist.f -o sim_tb
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^Result: PASSED$" sim.log; then
  exit 0
else
  exit 1
fi

//--- verification/axi_mem_slave.sv
`default_nettype none

module axi_mem_slave (
  input  logic                               clk_i,
  // write address and data
  input  logic                               aw_valid_i,
  output logic                               aw_ready_o,
  input  logic [axi_adapter_pkg::ADDR_W-1:0] aw_addr_i,
  input  logic [axi_adapter_pkg::LEN_W-1:0]  aw_len_i,
  input  logic [axi_adapter_pkg::ID_W-1:0]   aw_id_i,
  input  logic                               w_valid_i,
  output logic                               w_ready_o,
  input  logic [axi_adapter_pkg::DATA_W-1:0] w_data_i,
  input  logic [axi_adapter_pkg::STRB_W-1:0] w_strb_i,
  input  logic                               w_last_i,
  output logic                               b_valid_o,
  input  logic                               b_ready_i,
  output logic [axi_adapter_pkg::ID_W-1:0]   b_id_o,
  // read address and data
  input  logic                               ar_valid_i,
  output logic                               ar_ready_o,
  input  logic [axi_adapter_pkg::ADDR_W-1:0] ar_addr_i,
  input  logic [axi_adapter_pkg::LEN_W-1:0]  ar_len_i,
  input  logic [axi_adapter_pkg::ID_W-1:0]   ar_id_i,
  output logic                               r_valid_o,
  input  logic                               r_ready_i,
  output logic [axi_adapter_pkg::DATA_W-1:0] r_data_o,
  output logic [axi_adapter_pkg::ID_W-1:0]   r_id_o,
  output logic                               r_last_o,
  // last transfers seen, for the testbench checks
  output logic [axi_adapter_pkg::ADDR_W-1:0] wr_addr_o,
  output logic [axi_adapter_pkg::LEN_W-1:0]  wr_len_o,
  output int                                 wr_beats_o,
  output int                                 wr_last_pos_o,
  output logic [axi_adapter_pkg::ADDR_W-1:0] rd_addr_o,
  output logic [axi_adapter_pkg::LEN_W-1:0]  rd_len_o
);

  import axi_adapter_pkg::*;

  // 64 words, filled by the testbench
  logic [DATA_W-1:0] mem [64];

  // --------------------
  // write side
  // --------------------

  initial begin : write_side
    logic [DATA_W-1:0] data_q [$];
    logic [STRB_W-1:0] strb_q [$];
    logic [5:0]        base;
    logic [5:0]        idx;
    logic [ID_W-1:0]   id;
    logic              aw_done;
    logic              w_done;
    int                aw_wait;
    int                w_wait;
    int                delay;
    aw_ready_o    = 1'b0;
    w_ready_o     = 1'b0;
    b_valid_o     = 1'b0;
    b_id_o        = '0;
    wr_addr_o     = '0;
    wr_len_o      = '0;
    wr_beats_o    = 0;
    wr_last_pos_o = -1;
    forever begin
      @(negedge clk_i);
      if (aw_valid_i) begin
        data_q.delete();
        strb_q.delete();
        aw_done       = 1'b0;
        w_done        = 1'b0;
        aw_wait       = $urandom_range(3);
        w_wait        = $urandom_range(3);
        wr_last_pos_o = -1;
        id            = '0;
        base          = '0;
        while (!(aw_done && w_done)) begin
          @(posedge clk_i);
          #1;
          aw_ready_o = !aw_done && (aw_wait == 0);
          w_ready_o  = !w_done && (w_wait == 0);
          if (aw_wait > 0) aw_wait--;
          if (w_wait > 0) w_wait--;
          @(negedge clk_i);
          if (aw_ready_o && aw_valid_i) begin
            wr_addr_o = aw_addr_i;
            wr_len_o  = aw_len_i;
            base      = aw_addr_i[8:3];
            id        = aw_id_i;
            aw_done   = 1'b1;
          end
          if (w_ready_o && w_valid_i) begin
            data_q.push_back(w_data_i);
            strb_q.push_back(w_strb_i);
            if (w_last_i) begin
              wr_last_pos_o = data_q.size() - 1;
              w_done        = 1'b1;
            end
            w_wait = $urandom_range(3);
          end
        end
        @(posedge clk_i);
        #1;
        aw_ready_o = 1'b0;
        w_ready_o  = 1'b0;
        wr_beats_o = data_q.size();
        // beats land at ascending words from the burst address
        for (int i = 0; i < data_q.size(); i++) begin
          idx = base + 6'(i);
          for (int b = 0; b < STRB_W; b++) begin
            if (strb_q[i][b]) mem[idx][b*8 +: 8] = data_q[i][b*8 +: 8];
          end
        end
        delay = $urandom_range(3);
        repeat (delay) begin
          @(posedge clk_i);
          #1;
        end
        b_valid_o = 1'b1;
        b_id_o    = id;
        do @(negedge clk_i); while (!b_ready_i);
        @(posedge clk_i);
        #1;
        b_valid_o = 1'b0;
      end
    end
  end

  // --------------------
  // read side
  // --------------------

  initial begin : read_side
    logic [5:0]      base;
    logic [LEN_W-1:0] len;
    logic [ID_W-1:0] id;
    logic            done;
    int              ar_wait;
    int              delay;
    ar_ready_o = 1'b0;
    r_valid_o  = 1'b0;
    r_data_o   = '0;
    r_id_o     = '0;
    r_last_o   = 1'b0;
    rd_addr_o  = '0;
    rd_len_o   = '0;
    forever begin
      @(negedge clk_i);
      if (ar_valid_i) begin
        done    = 1'b0;
        ar_wait = $urandom_range(3);
        base    = '0;
        len     = '0;
        id      = '0;
        while (!done) begin
          @(posedge clk_i);
          #1;
          ar_ready_o = (ar_wait == 0);
          if (ar_wait > 0) ar_wait--;
          @(negedge clk_i);
          if (ar_ready_o && ar_valid_i) begin
            rd_addr_o = ar_addr_i;
            rd_len_o  = ar_len_i;
            base      = ar_addr_i[8:3];
            len       = ar_len_i;
            id        = ar_id_i;
            done      = 1'b1;
          end
        end
        @(posedge clk_i);
        #1;
        ar_ready_o = 1'b0;
        for (int i = 0; i <= int'(len); i++) begin
          r_valid_o = 1'b0;
          delay     = $urandom_range(3);
          repeat (delay) begin
            @(posedge clk_i);
            #1;
          end
          r_valid_o = 1'b1;
          r_data_o  = mem[base + 6'(i)];
          r_id_o    = id;
          r_last_o  = (i == int'(len));
          do @(negedge clk_i); while (!r_ready_i);
          @(posedge clk_i);
          #1;
        end
        r_valid_o = 1'b0;
        r_last_o  = 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

//--- verification/tb_axi_adapter.sv
`default_nettype none

module tb_axi_adapter;

  import axi_adapter_pkg::*;

  localparam int PAIRS = 100;
  localparam int REQS  = 2 * PAIRS;
  localparam int CYCLE = 8;

  logic                     clk_i;
  logic                     rst_ni;
  logic                     req_i;
  logic                     line_i;
  logic                     we_i;
  logic [ADDR_W-1:0]        addr_i;
  logic [1:0]               size_i;
  logic [ID_W-1:0]          id_i;
  logic [LINE_W-1:0]        wdata_i;
  logic [BEATS*STRB_W-1:0]  be_i;
  logic                     gnt_o;
  logic                     valid_o;
  logic [LINE_W-1:0]        rdata_o;
  logic [ID_W-1:0]          id_o;
  logic [DATA_W-1:0]        critical_word_o;
  logic                     critical_word_valid_o;
  logic                     aw_valid_o;
  logic                     aw_ready_i;
  logic                     w_valid_o;
  logic                     w_ready_i;
  logic                     w_last_o;
  logic                     b_valid_i;
  logic                     b_ready_o;
  logic                     ar_valid_o;
  logic                     ar_ready_i;
  logic                     r_valid_i;
  logic                     r_ready_o;
  logic                     r_last_i;
  logic [ADDR_W-1:0]        aw_addr_o;
  logic [ADDR_W-1:0]        ar_addr_o;
  logic [ADDR_W-1:0]        wr_addr;
  logic [ADDR_W-1:0]        rd_addr;
  logic [LEN_W-1:0]         aw_len_o;
  logic [LEN_W-1:0]         ar_len_o;
  logic [LEN_W-1:0]         wr_len;
  logic [LEN_W-1:0]         rd_len;
  logic [SIZE_W-1:0]        aw_size_o;
  logic [SIZE_W-1:0]        ar_size_o;
  logic [ID_W-1:0]          aw_id_o;
  logic [ID_W-1:0]          ar_id_o;
  logic [ID_W-1:0]          b_id_i;
  logic [ID_W-1:0]          r_id_i;
  logic [DATA_W-1:0]        w_data_o;
  logic [DATA_W-1:0]        r_data_i;
  logic [STRB_W-1:0]        w_strb_o;
  int                       wr_beats;
  int                       wr_last_pos;

  // reference memory, one entry per word
  logic [DATA_W-1:0] model [int];
  int                errors;
  int                checks;

  axi_adapter dut_i (.*);

  axi_mem_slave mem_i (
    .clk_i         (clk_i),
    .aw_valid_i    (aw_valid_o),
    .aw_ready_o    (aw_ready_i),
    .aw_addr_i     (aw_addr_o),
    .aw_len_i      (aw_len_o),
    .aw_id_i       (aw_id_o),
    .w_valid_i     (w_valid_o),
    .w_ready_o     (w_ready_i),
    .w_data_i      (w_data_o),
    .w_strb_i      (w_strb_o),
    .w_last_i      (w_last_o),
    .b_valid_o     (b_valid_i),
    .b_ready_i     (b_ready_o),
    .b_id_o        (b_id_i),
    .ar_valid_i    (ar_valid_o),
    .ar_ready_o    (ar_ready_i),
    .ar_addr_i     (ar_addr_o),
    .ar_len_i      (ar_len_o),
    .ar_id_i       (ar_id_o),
    .r_valid_o     (r_valid_i),
    .r_ready_i     (r_ready_o),
    .r_data_o      (r_data_i),
    .r_id_o        (r_id_i),
    .r_last_o      (r_last_i),
    .wr_addr_o     (wr_addr),
    .wr_len_o      (wr_len),
    .wr_beats_o    (wr_beats),
    .wr_last_pos_o (wr_last_pos),
    .rd_addr_o     (rd_addr),
    .rd_len_o      (rd_len)
  );

  initial begin
    clk_i = 1'b0;
    forever #(CYCLE / 2) clk_i = ~clk_i;
  end

  task automatic check_eq(input string name, input logic [LINE_W-1:0] exp,
                          input logic [LINE_W-1:0] got);
    checks++;
    if (exp !== got) begin
      errors++;
      $display("[ERROR] %0t %s exp %0h got %0h", $time, name, exp, got);
    end
  endtask

  function automatic logic [DATA_W-1:0] word_fill(input int k);
    return {32'(k) * 32'h9e37_79b1, 32'hc0de_0000 | 32'(k)};
  endfunction

  task automatic check_idle();
    check_eq("gnt_o", '0, LINE_W'(gnt_o));
    check_eq("valid_o", '0, LINE_W'(valid_o));
    check_eq("critical_word_valid_o", '0, LINE_W'(critical_word_valid_o));
    check_eq("axi valids", '0, LINE_W'({aw_valid_o, w_valid_o, ar_valid_o}));
    check_eq("axi readies", '0, LINE_W'({b_ready_o, r_ready_o}));
  endtask

  // one request from drive to response, checked against the model
  task automatic run_request(input logic we, input logic line, input logic [ADDR_W-1:0] addr);
    logic [31:0]           r;
    logic [ID_W-1:0]       id;
    logic [1:0]            size;
    logic [SIZE_W-1:0]     exp_size;
    logic [LINE_W-1:0]     wdata;
    logic [ADDR_W-1:0]     exp_addr;
    logic [5:0]            base;
    logic [BEAT_IDX_W-1:0] crit;
    int                    n_words;
    int                    crit_cnt;
    r = $urandom;
    id = r[ID_W-1:0];
    size = r[5:4];
    for (int i = 0; i < LINE_W / 32; i++) wdata[i*32 +: 32] = $urandom;
    n_words  = line ? BEATS : 1;
    base     = line ? {addr[8:5], 2'b00} : addr[8:3];
    crit     = addr[4:3];
    exp_addr = line ? {addr[ADDR_W-1:5], 5'b0} : addr;
    // line beats carry a whole word each
    exp_size = line ? SIZE_W'($clog2(DATA_W / 8)) : {1'b0, size};
    crit_cnt = 0;
    @(posedge clk_i);
    #1;
    req_i   = 1'b1;
    we_i    = we;
    line_i  = line;
    addr_i  = addr;
    size_i  = size;
    id_i    = id;
    wdata_i = wdata;
    be_i    = $urandom;
    do begin
      @(negedge clk_i);
      check_eq("valid_o", '0, LINE_W'(valid_o));
      if (aw_valid_o) begin
        check_eq("aw_size_o", LINE_W'(exp_size), LINE_W'(aw_size_o));
      end
      if (ar_valid_o) begin
        check_eq("ar_size_o", LINE_W'(exp_size), LINE_W'(ar_size_o));
      end
    end while (!gnt_o);
    if (we) begin
      for (int i = 0; i < n_words; i++) begin
        for (int b = 0; b < STRB_W; b++) begin
          if (be_i[i*STRB_W+b]) model[int'(base)+i][b*8 +: 8] = wdata[i*DATA_W+b*8 +: 8];
        end
      end
    end
    @(posedge clk_i);
    #1;
    req_i = 1'b0;
    do begin
      @(negedge clk_i);
      check_eq("gnt_o", '0, LINE_W'(gnt_o));
      if (critical_word_valid_o) begin
        crit_cnt++;
        check_eq("critical_word_o", LINE_W'(model[int'(base)+int'(crit)]),
                 LINE_W'(critical_word_o));
      end
    end while (!valid_o);
    check_eq("id_o", LINE_W'(id), LINE_W'(id_o));
    check_eq("critical count", LINE_W'((line && !we) ? 1 : 0), LINE_W'(crit_cnt));
    if (we) begin
      check_eq("aw_addr", LINE_W'(exp_addr), LINE_W'(wr_addr));
      check_eq("aw_len", LINE_W'(n_words - 1), LINE_W'(wr_len));
      check_eq("w beats", LINE_W'(n_words), LINE_W'(wr_beats));
      check_eq("w_last beat", LINE_W'(n_words - 1), LINE_W'(wr_last_pos));
    end else begin
      check_eq("ar_addr", LINE_W'(exp_addr), LINE_W'(rd_addr));
      check_eq("ar_len", LINE_W'(n_words - 1), LINE_W'(rd_len));
      for (int i = 0; i < n_words; i++) begin
        check_eq("rdata_o", LINE_W'(model[int'(base)+i]), LINE_W'(rdata_o[i*DATA_W +: DATA_W]));
      end
    end
    // exactly one response per request
    @(negedge clk_i);
    check_eq("valid_o", '0, LINE_W'(valid_o));
  endtask

  initial begin
    logic [31:0] r;
    void'($urandom(60574));
    errors  = 0;
    checks  = 0;
    rst_ni  = 1'b0;
    req_i   = 1'b0;
    line_i  = 1'b0;
    we_i    = 1'b0;
    addr_i  = '0;
    size_i  = 2'd3;
    id_i    = '0;
    wdata_i = '0;
    be_i    = '0;
    for (int k = 0; k < 64; k++) begin
      model[k]   = word_fill(k);
      mem_i.mem[k] = word_fill(k);
    end
    @(negedge clk_i);
    check_idle();
    repeat (2) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    @(negedge clk_i);
    check_idle();
    // each write is followed by a read of the same address
    for (int p = 0; p < PAIRS; p++) begin
      r = $urandom;
      run_request(1'b1, r[9], {23'b0, r[8:0]});
      run_request(1'b0, r[10], {23'b0, r[8:0]});
    end
    $display("checks: %0d  errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

  // watchdog
  initial begin
    #(REQS * 40 * CYCLE);
    $display("timeout: the requests did not complete within %0d cycles", REQS * 40);
    $display("Result: FAILED");
    $finish;
  end

endmodule

`default_nettype wire
